//--- Makefile
TOOL       := verilator
TOP        := pc_profiler_tb
FILELIST   := pc_profiler.f
OBJ_DIR    := obj_dir
COMMON     := --timing --assert --timescale 1ns/100ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON) -j 0
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- pc_profiler.f
+incdir+rtl
rtl/pc_profiler_pkg.sv
rtl/pc_event_classifier.sv
rtl/pc_bin_mapper.sv
rtl/pc_hist_counter.sv
rtl/pc_profiler.sv
testbench/pc_profiler_sva.sv
testbench/pc_profiler_tb.sv

//--- rtl/pc_bin_mapper.sv
`include "pc_profiler_consts.svh"

module pc_bin_mapper (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        event_valid_i,
  input  pc_profiler_pkg::pc_event_s  event_i,
  output logic                        bin_valid_o,
  output pc_profiler_pkg::bin_event_s bin_event_o
);

  logic [`PC_W-1:0]            offset;
  logic [`PC_W-1:0]            index;
  logic                        out_of_range;
  pc_profiler_pkg::bin_event_s bin_ev;
  logic                        bin_valid_r;
  pc_profiler_pkg::bin_event_s bin_ev_r;

  assign offset = event_i.pc - `PC_BASE;
  assign index  = offset >> `BIN_SHIFT;

  // below the base or past the table, fold into the last bin
  assign out_of_range = (event_i.pc < `PC_BASE) || (index >= (`NUM_BINS - 1));

  always_comb begin
    bin_ev.kind = event_i.kind;
    bin_ev.bin  = out_of_range ? `BIN_W'(`NUM_BINS - 1) : index[`BIN_W-1:0];
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bin_valid_r <= 1'b0;
    end else begin
      bin_valid_r <= event_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    bin_ev_r <= bin_ev;
  end

  assign bin_valid_o = bin_valid_r;
  assign bin_event_o = bin_ev_r;

endmodule

//--- rtl/pc_event_classifier.sv
`include "pc_profiler_consts.svh"

module pc_event_classifier (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          sample_valid_i,
  input  pc_profiler_pkg::trace_sample_s sample_i,
  output logic                          event_valid_o,
  output pc_profiler_pkg::pc_event_s    event_o
);

  logic [`PC_W-1:0]           fp_pc_r; // pc of the op in FP execute
  logic                       ev_valid;
  pc_profiler_pkg::pc_event_s ev;
  logic                       ev_valid_r;
  pc_profiler_pkg::pc_event_s ev_r;

  // follow the instruction from decode into the FP execute stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fp_pc_r <= '0;
    end else if (sample_valid_i && !sample_i.stall_all && !sample_i.stall_id) begin
      fp_pc_r <= sample_i.id_pc;
    end
  end

  // first matching rule wins
  always_comb begin
    ev_valid = 1'b0;
    ev.pc    = sample_i.exe_pc;
    ev.kind  = pc_profiler_pkg::e_kind_instr;
    if (!sample_i.stall_all && sample_i.exe_instr_valid && !sample_i.exe_icache_miss) begin
      ev_valid = 1'b1;
    end else if (sample_i.fp_op_valid && !sample_i.stall_all) begin
      ev_valid = 1'b1;
      ev.pc    = fp_pc_r; // value before this sample's update
      ev.kind  = pc_profiler_pkg::e_kind_fp;
    end else if (sample_i.bubble_valid) begin
      ev_valid = 1'b1;
      ev.pc    = sample_i.bubble_pc;
      ev.kind  = pc_profiler_pkg::e_kind_stall;
    end else if (sample_i.stall_all) begin
      ev_valid = 1'b1;
      ev.kind  = pc_profiler_pkg::e_kind_stall;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ev_valid_r <= 1'b0;
    end else begin
      ev_valid_r <= sample_valid_i & ev_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    ev_r <= ev;
  end

  assign event_valid_o = ev_valid_r;
  assign event_o       = ev_r;

endmodule

//--- rtl/pc_hist_counter.sv
`include "pc_profiler_consts.svh"

module pc_hist_counter (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         bin_valid_i,
  input  pc_profiler_pkg::bin_event_s  bin_event_i,
  input  logic                         query_valid_i,
  input  pc_profiler_pkg::hist_query_s query_i,
  output logic                         query_ready_o,
  output logic                         count_valid_o,
  output logic [`COUNT_W-1:0]          count_o,
  input  logic                         count_ready_i
);

  // one counter per bin and kind, three kinds
  logic [`COUNT_W-1:0] counts_r [`NUM_BINS][3];

  logic [`COUNT_W-1:0] cur_count;
  logic                at_max;
  logic                query_fire;
  logic                count_valid_r;
  logic [`COUNT_W-1:0] count_r;

  assign cur_count = counts_r[bin_event_i.bin][bin_event_i.kind];
  assign at_max    = (cur_count == {`COUNT_W{1'b1}});

  // event owns the access port; a waiting response blocks new queries
  assign query_ready_o = ~count_valid_r & ~bin_valid_i;
  assign query_fire    = query_valid_i & query_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int b = 0; b < `NUM_BINS; b++) begin
        for (int k = 0; k < 3; k++) begin
          counts_r[b][k] <= '0;
        end
      end
    end else if (bin_valid_i && !at_max) begin
      counts_r[bin_event_i.bin][bin_event_i.kind] <= cur_count + 1'b1;
    end
  end

  // response handshake
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_valid_r <= 1'b0;
    end else if (query_fire) begin
      count_valid_r <= 1'b1;
    end else if (count_ready_i) begin
      count_valid_r <= 1'b0;
    end
  end

  // held until the consumer takes it
  always_ff @(posedge clk_i) begin
    if (query_fire) begin
      count_r <= counts_r[query_i.bin][query_i.kind];
    end
  end

  assign count_valid_o = count_valid_r;
  assign count_o       = count_r;

endmodule

//--- rtl/pc_profiler.sv
`include "pc_profiler_consts.svh"

module pc_profiler (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          sample_valid_i,
  input  pc_profiler_pkg::trace_sample_s sample_i,
  input  logic                          query_valid_i,
  input  pc_profiler_pkg::hist_query_s  query_i,
  output logic                          query_ready_o,
  output logic                          count_valid_o,
  output logic [`COUNT_W-1:0]           count_o,
  input  logic                          count_ready_i
);

  logic                        event_valid;
  pc_profiler_pkg::pc_event_s  pc_event;
  logic                        bin_valid;
  pc_profiler_pkg::bin_event_s bin_event;

  pc_event_classifier u_classifier (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .event_valid_o  (event_valid),
    .event_o        (pc_event)
  );

  pc_bin_mapper u_mapper (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .event_valid_i (event_valid),
    .event_i       (pc_event),
    .bin_valid_o   (bin_valid),
    .bin_event_o   (bin_event)
  );

  pc_hist_counter u_counter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .bin_valid_i   (bin_valid),
    .bin_event_i   (bin_event),
    .query_valid_i (query_valid_i),
    .query_i       (query_i),
    .query_ready_o (query_ready_o),
    .count_valid_o (count_valid_o),
    .count_o       (count_o),
    .count_ready_i (count_ready_i)
  );

endmodule

//--- rtl/pc_profiler_consts.svh
`ifndef PC_PROFILER_CONSTS_SVH
`define PC_PROFILER_CONSTS_SVH

// PC geometry
`define PC_W      32
`define PC_BASE   32'h0000_1000 // first binned address

// each bin covers 1 << BIN_SHIFT bytes
`define BIN_SHIFT 4
`define NUM_BINS  16
`define BIN_W     4

// saturating counter width
`define COUNT_W   8

`endif

//--- rtl/pc_profiler_pkg.sv
`include "pc_profiler_consts.svh"

package pc_profiler_pkg;

  typedef enum logic [1:0] {
    e_kind_instr = 2'd0,
    e_kind_fp    = 2'd1,
    e_kind_stall = 2'd2
  } event_kind_e;

  // core state seen each cycle
  typedef struct packed {
    logic [`PC_W-1:0] exe_pc;
    logic [`PC_W-1:0] id_pc;
    logic             exe_instr_valid;
    logic             exe_icache_miss;
    logic             stall_all;
    logic             stall_id;
    logic             fp_op_valid;
    logic             bubble_valid;
    logic [`PC_W-1:0] bubble_pc; // stands in for the bubble classifier
  } trace_sample_s;

  typedef struct packed {
    logic [`PC_W-1:0] pc;
    event_kind_e      kind;
  } pc_event_s;

  typedef struct packed {
    logic [`BIN_W-1:0] bin;
    event_kind_e       kind;
  } bin_event_s;

  // address of one counter
  typedef struct packed {
    logic [`BIN_W-1:0] bin;
    event_kind_e       kind;
  } hist_query_s;

endpackage

//--- testbench/pc_profiler_sva.sv
`include "pc_profiler_consts.svh"

module pc_profiler_sva (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        bin_valid_i,
  input pc_profiler_pkg::bin_event_s bin_event_i,
  input logic                        query_ready_i,
  input logic                        count_valid_i,
  input logic [`COUNT_W-1:0]         count_i,
  input logic                        count_ready_i,
  input logic [`COUNT_W-1:0]         counts_i [`NUM_BINS][3]
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`BIN_W-1:0] last_bin; // counter touched by the previous event
  logic [1:0]        last_kind;

  always_ff @(posedge clk_i) begin
    last_bin  <= bin_event_i.bin;
    last_kind <= bin_event_i.kind;
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    count_valid_i && !count_ready_i |=> count_valid_i && $stable(count_i))
    else $error("held response changed before count_ready_i");

  assert property (@(posedge clk_i) disable iff (reset_i)
    bin_valid_i |-> !query_ready_i)
    else $error("query port ready during a counter update");

  // a full counter must stay full
  assert property (@(posedge clk_i) disable iff (reset_i)
    bin_valid_i && (counts_i[bin_event_i.bin][bin_event_i.kind] == '1)
    |=> counts_i[last_bin][last_kind] == '1)
    else $error("counter wrapped past its maximum");

endmodule

bind pc_hist_counter pc_profiler_sva u_sva (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .bin_valid_i   (bin_valid_i),
  .bin_event_i   (bin_event_i),
  .query_ready_i (query_ready_o),
  .count_valid_i (count_valid_o),
  .count_i       (count_o),
  .count_ready_i (count_ready_i),
  .counts_i      (counts_r)
);

//--- testbench/pc_profiler_tb.sv
`include "pc_profiler_consts.svh"

module pc_profiler_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct {
    byte                            op;
    int                             rep;
    pc_profiler_pkg::trace_sample_s smp;
    int                             bin;
    int                             kind;
    int                             expected;
  } step_s;

  logic                          clk_i;
  logic                          reset_i;
  logic                          sample_valid_i;
  pc_profiler_pkg::trace_sample_s sample_i;
  logic                          query_valid_i;
  pc_profiler_pkg::hist_query_s  query_i;
  logic                          query_ready_o;
  logic                          count_valid_o;
  logic [`COUNT_W-1:0]           count_o;
  logic                          count_ready_i;

  step_s            steps[$];
  int               model_count [`NUM_BINS][3]; // reference histogram
  logic [`PC_W-1:0] model_fp_pc;
  bit               samples_pending;
  int               limit_cycles = 0;
  int               total_reps = 0;

  pc_profiler u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, actual, expected);
      abort_run("value mismatch");
    end
  endtask

  function automatic int bin_of(input logic [`PC_W-1:0] pc);
    logic [`PC_W-1:0] idx;
    if (pc < `PC_BASE) return `NUM_BINS - 1; // below the table
    idx = (pc - `PC_BASE) >> `BIN_SHIFT;
    if (idx >= `NUM_BINS - 1) return `NUM_BINS - 1;
    return int'(idx);
  endfunction

  task automatic model_sample(input pc_profiler_pkg::trace_sample_s s);
    bit               hit;
    int               kind;
    int               bin;
    logic [`PC_W-1:0] pc;
    hit  = 1'b1;
    kind = 0;
    pc   = s.exe_pc;
    if (!s.stall_all && s.exe_instr_valid && !s.exe_icache_miss) begin
      kind = 0;
    end else if (s.fp_op_valid && !s.stall_all) begin
      kind = 1;
      pc   = model_fp_pc; // pc from before this sample
    end else if (s.bubble_valid) begin
      kind = 2;
      pc   = s.bubble_pc;
    end else if (s.stall_all) begin
      kind = 2;
    end else begin
      hit = 1'b0;
    end
    if (!s.stall_all && !s.stall_id) model_fp_pc = s.id_pc;
    if (hit) begin
      bin = bin_of(pc);
      if (model_count[bin][kind] < (1 << `COUNT_W) - 1) model_count[bin][kind]++;
    end
  endtask

  task automatic load_tests();
    int               fd;
    int               n;
    int               iv, im, sa, si, fp, bv;
    logic [`PC_W-1:0] exe, id, bpc;
    string            line;
    step_s            st;
    fd = $fopen("testbench/pc_profiler_tests.txt", "r");
    if (fd == 0) abort_run("could not open testbench/pc_profiler_tests.txt");
    while ($fgets(line, fd) != 0) begin
      st = '{default: 0};
      st.op = line[0];
      case (line[0])
        "S": begin
          n = $sscanf(line, "S %d %h %h %d %d %d %d %d %d %h",
                      st.rep, exe, id, iv, im, sa, si, fp, bv, bpc);
          if (n != 10) abort_run({"malformed sample line: ", line});
          st.smp.exe_pc          = exe;
          st.smp.id_pc           = id;
          st.smp.exe_instr_valid = (iv != 0);
          st.smp.exe_icache_miss = (im != 0);
          st.smp.stall_all       = (sa != 0);
          st.smp.stall_id        = (si != 0);
          st.smp.fp_op_valid     = (fp != 0);
          st.smp.bubble_valid    = (bv != 0);
          st.smp.bubble_pc       = bpc;
          total_reps += st.rep;
          steps.push_back(st);
        end
        "Q": begin
          n = $sscanf(line, "Q %d %d %d", st.bin, st.kind, st.expected);
          if (n != 3) abort_run({"malformed query line: ", line});
          steps.push_back(st);
        end
        "R": steps.push_back(st);
        "#", "\n": ;
        default: abort_run({"unknown line in test data: ", line});
      endcase
    end
    $fclose(fd);
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    reset_i        <= 1'b1;
    sample_valid_i <= 1'b0;
    query_valid_i  <= 1'b0;
    count_ready_i  <= 1'b0;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    model_count     = '{default: 0};
    model_fp_pc     = '0;
    samples_pending = 1'b0;
  endtask

  task automatic run_sample(input step_s st);
    repeat (st.rep) begin
      @(posedge clk_i);
      sample_valid_i <= 1'b1;
      sample_i       <= st.smp;
      model_sample(st.smp);
    end
    samples_pending = 1'b1;
  endtask

  task automatic run_query(input step_s st);
    int                           hold;
    int                           want;
    logic [`COUNT_W-1:0]          first;
    pc_profiler_pkg::hist_query_s q;
    if (samples_pending) begin
      repeat (3) begin // let the pipeline drain
        @(posedge clk_i);
        sample_valid_i <= 1'b0;
      end
      samples_pending = 1'b0;
    end
    want = model_count[st.bin][st.kind];
    check_value(st.expected, want, "test data count differs from model");
    q.bin  = `BIN_W'(st.bin);
    q.kind = pc_profiler_pkg::event_kind_e'(2'(st.kind));
    @(posedge clk_i);
    sample_valid_i <= 1'b0;
    query_valid_i  <= 1'b1;
    query_i        <= q;
    @(negedge clk_i);
    while (!query_ready_o) @(negedge clk_i);
    @(posedge clk_i); // query accepted here
    query_valid_i <= 1'b0;
    @(negedge clk_i);
    check_value(int'(count_valid_o), 1, "no response one cycle after the query");
    check_value(int'(query_ready_o), 0, "query port ready while a response waits");
    first = count_o;
    hold  = $urandom_range(3, 0);
    repeat (hold) @(negedge clk_i);
    check_value(int'(count_valid_o), 1, "response dropped before count_ready_i");
    check_value(int'(count_o), int'(first), "response changed while held");
    check_value(int'(count_o), want, $sformatf("count of bin %0d kind %0d", st.bin, st.kind));
    @(posedge clk_i);
    count_ready_i <= 1'b1;
    @(posedge clk_i);
    count_ready_i <= 1'b0;
    @(negedge clk_i);
    check_value(int'(count_valid_o), 0, "response still valid after handshake");
  endtask

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    abort_run("Timeout: the run hung and did not finish within the cycle limit");
  end

  initial begin
    void'($urandom(70));
    reset_i        <= 1'b1;
    sample_valid_i <= 1'b0;
    sample_i       <= '0;
    query_valid_i  <= 1'b0;
    query_i        <= '0;
    count_ready_i  <= 1'b0;
    load_tests();
    limit_cycles = 20 * (steps.size() + 1) + 5 * total_reps;
    apply_reset();
    foreach (steps[i]) begin
      case (steps[i].op)
        "S": run_sample(steps[i]);
        "Q": run_query(steps[i]);
        default: apply_reset(); // mid-run reset clears every counter
      endcase
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- testbench/pc_profiler_tests.txt
# S repeat exe_pc id_pc instr_valid icache_miss stall_all stall_id fp_op bubble bubble_pc
# Q bin kind expected_count (kind 0 instr, 1 fp, 2 stall); R resets the DUT
S 1 00001000 00001010 1 0 0 0 1 0 00000000
S 1 00001020 00001030 0 0 1 0 0 1 00001040
Q 0 0 1
Q 0 1 0
Q 4 2 1
S 1 00001050 00001060 0 0 0 1 0 0 00000000
S 1 00001054 00001070 0 0 0 0 1 0 00000000
S 1 00001058 00001080 0 0 0 0 1 0 00000000
Q 1 1 1
Q 6 1 0
Q 7 1 1
S 2 000010a4 00001090 1 0 0 0 0 0 00000000
S 1 00000800 00001094 1 0 0 0 0 0 00000000
S 1 80000000 00001098 1 0 0 0 0 0 00000000
S 1 000010f0 0000109c 1 0 0 0 0 0 00000000
S 1 00001030 000010a0 1 1 0 0 0 0 00000000
S 3 00001020 000010a4 1 0 1 0 0 0 00000000
Q 10 0 2
Q 15 0 3
Q 3 0 0
Q 2 2 3
S 300 00001050 000010b0 1 0 0 0 0 0 00000000
Q 5 0 255
Q 0 0 1
R
Q 5 0 0
Q 15 0 0
S 1 00001060 00001070 0 0 0 0 1 0 00000000
Q 15 1 1
